// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire logic                    clock,
	input  wire logic                    arst_n,
	input  wire logic                    squash,
	fu_exec_if.exec                      exe,
	output logic [fu_pkg::xlen-1:0]      result,
	output logic                         result_valid
);
	import fu_pkg::*;

	logic                   in_valid;
	logic [xlen-1:0]        in_opa, in_opb;
	alu_func_e              in_func;
	logic [xlen-1:0]        out_result;
	logic signed [2*xlen-1:0] signed_mul, mixed_mul;
	logic [2*xlen-1:0]      unsigned_mul;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			in_valid <= 1'b0;
		else
			in_valid <= exe.valid && !squash;
	end

	always_ff @(posedge clock) begin
		in_opa  <= exe.opa;
		in_opb  <= exe.opb;
		in_func <= exe.func;
	end

	assign signed_mul   = $signed(in_opa) * $signed(in_opb);
	assign unsigned_mul = in_opa * in_opb;
	// rs1 signed, rs2 unsigned, both widened by hand
	assign mixed_mul    = $signed({{xlen{in_opa[xlen-1]}}, in_opa}) *
	                      $signed({{xlen{1'b0}}, in_opb});

	always_comb begin
		case (in_func)
			alu_add:    out_result = in_opa + in_opb;
			alu_sub:    out_result = in_opa - in_opb;
			alu_and:    out_result = in_opa & in_opb;
			alu_or:     out_result = in_opa | in_opb;
			alu_xor:    out_result = in_opa ^ in_opb;
			alu_slt:    out_result = {{(xlen-1){1'b0}}, $signed(in_opa) < $signed(in_opb)};
			alu_sltu:   out_result = {{(xlen-1){1'b0}}, in_opa < in_opb};
			alu_sll:    out_result = in_opa << in_opb[4:0];
			alu_srl:    out_result = in_opa >> in_opb[4:0];
			alu_sra:    out_result = $signed(in_opa) >>> in_opb[4:0];
			alu_mul:    out_result = signed_mul[xlen-1:0];
			alu_mulh:   out_result = signed_mul[2*xlen-1:xlen];
			alu_mulhsu: out_result = mixed_mul[2*xlen-1:xlen];
			alu_mulhu:  out_result = unsigned_mul[2*xlen-1:xlen];
			default:    out_result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
			result       <= '0;
		end else begin
			result_valid <= in_valid && !squash;
			if (in_valid)
				result <= out_result; // holds between results
		end
	end

	// slot must only send encoded operations
	a_func_defined: assert property (@(posedge clock) disable iff (!arst_n)
		in_valid |-> !$isunknown(in_func) && (in_func <= alu_mulhu));

endmodule

`default_nettype wire

// ==== br_cond.sv ====
`timescale 1ns/10ps
`default_nettype none

module br_cond (
	input  wire logic clock,
	input  wire logic arst_n,
	input  wire logic squash,
	fu_exec_if.exec   exe,
	output logic      cond
);
	import fu_pkg::*;

	logic            in_valid;
	logic [xlen-1:0] in_rs1, in_rs2;
	br_func_e        in_func;
	logic            out_cond;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			in_valid <= 1'b0;
		else
			in_valid <= exe.valid && !squash;
	end

	always_ff @(posedge clock) begin
		in_rs1  <= exe.rs1;
		in_rs2  <= exe.rs2;
		in_func <= exe.br_func;
	end

	always_comb begin
		case (in_func)
			br_beq:  out_cond = in_rs1 == in_rs2;
			br_bne:  out_cond = in_rs1 != in_rs2;
			br_blt:  out_cond = $signed(in_rs1) < $signed(in_rs2);
			br_bge:  out_cond = $signed(in_rs1) >= $signed(in_rs2);
			br_bltu: out_cond = in_rs1 < in_rs2;
			br_bgeu: out_cond = in_rs1 >= in_rs2;
			default: out_cond = 1'b0; // funct3 010/011 never branch
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			cond <= 1'b0;
		else
			cond <= in_valid && !squash && out_cond;
	end

endmodule

`default_nettype wire

// ==== fu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_alu #(
	parameter int TAG_BITS = 5
) (
	input  wire logic                    clock,
	input  wire logic                    arst_n,
	input  wire logic                    issue_valid,
	input  wire logic [TAG_BITS-1:0]     issue_tag,
	input  wire logic [TAG_BITS-1:0]     src1_tag,
	input  wire logic                    src1_ready,
	input  wire logic [fu_pkg::xlen-1:0] src1_value,
	input  wire logic [TAG_BITS-1:0]     src2_tag,
	input  wire logic                    src2_ready,
	input  wire logic [fu_pkg::xlen-1:0] src2_value,
	input  wire logic [fu_pkg::xlen-1:0] pc,
	input  wire logic [31:0]             inst,
	input  wire fu_pkg::opa_sel_e        opa_select,
	input  wire fu_pkg::opb_sel_e        opb_select,
	input  wire fu_pkg::alu_func_e       alu_func,
	input  wire logic                    cond_branch,
	input  wire logic                    uncond_branch,
	input  wire logic                    squash,
	input  wire logic                    cdb_valid,
	input  wire logic [TAG_BITS-1:0]     cdb_tag,
	input  wire logic [fu_pkg::xlen-1:0] cdb_value,
	output logic                         busy,
	output logic                         done,
	output logic [TAG_BITS-1:0]          done_tag,
	output logic [fu_pkg::xlen-1:0]      result,
	output logic                         take_branch
);
	logic result_valid;
	logic cond;

	fu_exec_if #(.TAG_BITS(TAG_BITS)) exe_if ();

	fu_issue_slot #(.TAG_BITS(TAG_BITS)) u_slot (
		.clock, .arst_n, .issue_valid, .issue_tag,
		.src1_tag, .src1_ready, .src1_value,
		.src2_tag, .src2_ready, .src2_value,
		.pc, .inst, .opa_select, .opb_select, .alu_func,
		.cond_branch, .uncond_branch, .squash,
		.cdb_valid, .cdb_tag, .cdb_value,
		.busy, .exe(exe_if.issue)
	);

	alu u_alu (.clock, .arst_n, .squash, .exe(exe_if.exec), .result, .result_valid);

	br_cond u_br_cond (.clock, .arst_n, .squash, .exe(exe_if.exec), .cond);

	fu_complete #(.TAG_BITS(TAG_BITS)) u_complete (
		.clock, .arst_n, .squash, .exe(exe_if.track),
		.result_valid, .cond, .done, .done_tag, .take_branch
	);

endmodule

`default_nettype wire

// ==== fu_complete.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_complete #(
	parameter int TAG_BITS = 5
) (
	input  wire logic          clock,
	input  wire logic          arst_n,
	input  wire logic          squash,
	fu_exec_if.track           exe,
	input  wire logic          result_valid,
	input  wire logic          cond,
	output logic               done,
	output logic [TAG_BITS-1:0] done_tag,
	output logic               take_branch
);
	logic                s1_valid;
	logic [TAG_BITS-1:0] s1_tag;
	logic                s1_cond_br, s1_uncond_br;
	logic                s2_cond_br, s2_uncond_br;

	// first stage, alongside the alu input registers
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid     <= 1'b0;
			s1_tag       <= '0;
			s1_cond_br   <= 1'b0;
			s1_uncond_br <= 1'b0;
		end else begin
			s1_valid     <= exe.valid && !squash;
			s1_tag       <= exe.tag;
			s1_cond_br   <= exe.cond_branch;
			s1_uncond_br <= exe.uncond_branch;
		end
	end

	// second stage, alongside result
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			done_tag     <= '0;
			s2_cond_br   <= 1'b0;
			s2_uncond_br <= 1'b0;
		end else if (s1_valid && !squash) begin
			done_tag     <= s1_tag;
			s2_cond_br   <= s1_cond_br;
			s2_uncond_br <= s1_uncond_br;
		end
	end

	assign done        = result_valid;
	assign take_branch = done && (s2_uncond_br || (s2_cond_br && cond));

	a_done_tag_known: assert property (@(posedge clock) disable iff (!arst_n)
		done |-> !$isunknown(done_tag));

endmodule

`default_nettype wire

// ==== fu_exec_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one ready instruction from the slot into the execute stages
interface fu_exec_if #(
	parameter int TAG_BITS = 5
) ();
	import fu_pkg::*;

	logic                valid;  // one cycle per instruction
	logic [TAG_BITS-1:0] tag;
	logic [xlen-1:0]     opa;
	logic [xlen-1:0]     opb;
	alu_func_e           func;
	logic [xlen-1:0]     rs1;    // raw values for the compare
	logic [xlen-1:0]     rs2;
	br_func_e            br_func;
	logic                cond_branch;
	logic                uncond_branch;

	modport issue (
		output valid, tag, opa, opb, func, rs1, rs2, br_func,
		output cond_branch, uncond_branch
	);

	modport exec (
		input valid, opa, opb, func, rs1, rs2, br_func
	);

	// completion side only follows tag and branch kind
	modport track (
		input valid, tag, cond_branch, uncond_branch
	);

endinterface

`default_nettype wire

// ==== fu_issue_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_issue_slot #(
	parameter int TAG_BITS = 5
) (
	input  wire logic                     clock,
	input  wire logic                     arst_n,
	input  wire logic                     issue_valid,
	input  wire logic [TAG_BITS-1:0]      issue_tag,
	input  wire logic [TAG_BITS-1:0]      src1_tag,
	input  wire logic                     src1_ready,
	input  wire logic [fu_pkg::xlen-1:0]  src1_value,
	input  wire logic [TAG_BITS-1:0]      src2_tag,
	input  wire logic                     src2_ready,
	input  wire logic [fu_pkg::xlen-1:0]  src2_value,
	input  wire logic [fu_pkg::xlen-1:0]  pc,
	input  wire logic [31:0]              inst,
	input  wire fu_pkg::opa_sel_e         opa_select,
	input  wire fu_pkg::opb_sel_e         opb_select,
	input  wire fu_pkg::alu_func_e        alu_func,
	input  wire logic                     cond_branch,
	input  wire logic                     uncond_branch,
	input  wire logic                     squash,
	input  wire logic                     cdb_valid,
	input  wire logic [TAG_BITS-1:0]      cdb_tag,
	input  wire logic [fu_pkg::xlen-1:0]  cdb_value,
	output logic                          busy,
	fu_exec_if.issue                      exe
);
	import fu_pkg::*;

	logic                ent_valid;
	logic                rdy1, rdy2;
	logic [TAG_BITS-1:0] ent_tag, ent_tag1, ent_tag2;
	logic [xlen-1:0]     val1, val2, ent_pc;
	logic [31:0]         ent_inst;
	opa_sel_e            ent_opa_sel;
	opb_sel_e            ent_opb_sel;
	alu_func_e           ent_func;
	logic                ent_cond, ent_uncond;
	logic                launch;
	logic                snoop1, snoop2; // incoming issue hits the cdb
	logic                wake1, wake2;   // waiting source hits the cdb

	assign snoop1 = cdb_valid && (cdb_tag == src1_tag);
	assign snoop2 = cdb_valid && (cdb_tag == src2_tag);
	assign wake1  = cdb_valid && ent_valid && !rdy1 && (cdb_tag == ent_tag1);
	assign wake2  = cdb_valid && ent_valid && !rdy2 && (cdb_tag == ent_tag2);
	assign launch = ent_valid && rdy1 && rdy2;
	assign busy   = ent_valid && !(rdy1 && rdy2);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ent_valid <= 1'b0;
			rdy1      <= 1'b0;
			rdy2      <= 1'b0;
		end else if (squash) begin
			ent_valid <= 1'b0;
		end else if (issue_valid) begin
			ent_valid <= 1'b1;
			rdy1      <= src1_ready || snoop1;
			rdy2      <= src2_ready || snoop2;
		end else begin
			if (launch)
				ent_valid <= 1'b0;
			if (wake1)
				rdy1 <= 1'b1;
			if (wake2)
				rdy2 <= 1'b1;
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			ent_tag     <= issue_tag;
			ent_tag1    <= src1_tag;
			ent_tag2    <= src2_tag;
			val1        <= src1_ready ? src1_value : cdb_value;
			val2        <= src2_ready ? src2_value : cdb_value;
			ent_pc      <= pc;
			ent_inst    <= inst;
			ent_opa_sel <= opa_select;
			ent_opb_sel <= opb_select;
			ent_func    <= alu_func;
			ent_cond    <= cond_branch;
			ent_uncond  <= uncond_branch;
		end else begin
			if (wake1)
				val1 <= cdb_value;
			if (wake2)
				val2 <= cdb_value;
		end
	end

	always_comb begin
		case (ent_opa_sel)
			opa_is_rs1: exe.opa = val1;
			opa_is_npc: exe.opa = ent_pc + 32'd4;
			opa_is_pc:  exe.opa = ent_pc;
			default:    exe.opa = '0;
		endcase
	end

	always_comb begin
		case (ent_opb_sel)
			opb_is_rs2:   exe.opb = val2;
			opb_is_i_imm: exe.opb = {{20{ent_inst[31]}}, ent_inst[31:20]};
			opb_is_s_imm: exe.opb = {{20{ent_inst[31]}}, ent_inst[31:25], ent_inst[11:7]};
			opb_is_b_imm: exe.opb = {{19{ent_inst[31]}}, ent_inst[31], ent_inst[7],
			                         ent_inst[30:25], ent_inst[11:8], 1'b0};
			opb_is_u_imm: exe.opb = {ent_inst[31:12], 12'b0};
			opb_is_j_imm: exe.opb = {{11{ent_inst[31]}}, ent_inst[31], ent_inst[19:12],
			                         ent_inst[20], ent_inst[30:21], 1'b0};
			default:      exe.opb = '0;
		endcase
	end

	assign exe.valid         = launch;
	assign exe.tag           = ent_tag;
	assign exe.func          = ent_func;
	assign exe.rs1           = val1;
	assign exe.rs2           = val2;
	assign exe.br_func       = br_func_e'(ent_inst[14:12]); // funct3
	assign exe.cond_branch   = ent_cond;
	assign exe.uncond_branch = ent_uncond;

	// issuer has to honour busy
	a_no_issue_when_busy: assert property (@(posedge clock) disable iff (!arst_n)
		issue_valid |-> !busy);

endmodule

`default_nettype wire

// ==== fu_pkg.sv ====
`default_nettype none

package fu_pkg;

	localparam int xlen = 32; // RV32 operand width

	// alu operation
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_and    = 4'h2,
		alu_or     = 4'h3,
		alu_xor    = 4'h4,
		alu_slt    = 4'h5,
		alu_sltu   = 4'h6,
		alu_sll    = 4'h7,
		alu_srl    = 4'h8,
		alu_sra    = 4'h9,
		alu_mul    = 4'ha,
		alu_mulh   = 4'hb,
		alu_mulhsu = 4'hc,
		alu_mulhu  = 4'hd
	} alu_func_e;

	// operand a source
	typedef enum logic [1:0] {
		opa_is_rs1  = 2'h0,
		opa_is_npc  = 2'h1, // pc + 4
		opa_is_pc   = 2'h2,
		opa_is_zero = 2'h3
	} opa_sel_e;

	// operand b source
	typedef enum logic [2:0] {
		opb_is_rs2   = 3'h0,
		opb_is_i_imm = 3'h1,
		opb_is_s_imm = 3'h2,
		opb_is_b_imm = 3'h3,
		opb_is_u_imm = 3'h4,
		opb_is_j_imm = 3'h5
	} opb_sel_e;

	// branch condition, same encoding as funct3
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} br_func_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -j 0 --top-module tb_fu_alu -f sources.f -o sim_fu_alu &&
./obj_dir/sim_fu_alu | tee sim.log
grep -qx "Finished with no errors" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// ==== sources.f ====
fu_pkg.sv
fu_exec_if.sv
fu_issue_slot.sv
alu.sv
br_cond.sv
fu_complete.sv
fu_alu.sv
tb_fu_alu.sv

// ==== tb_fu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fu_alu;
	import fu_pkg::*;

	localparam int TAG_BITS = 5;

	// one instruction as the issuer sees it, t1/t2 are the source tags
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [TAG_BITS-1:0] t1;
		logic [TAG_BITS-1:0] t2;
		alu_func_e           func;
		opa_sel_e            opa_sel;
		opb_sel_e            opb_sel;
		logic [xlen-1:0]     rs1;
		logic [xlen-1:0]     rs2;
		logic [xlen-1:0]     pc;
		logic [31:0]         inst;
		logic                cond;
		logic                uncond;
	} instr_t;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [xlen-1:0]     result;
		logic                take;
		logic                timed;   // sources ready at issue
		logic [31:0]         at_edge;
	} expect_t;

	logic                clock;
	logic                arst_n;
	logic                issue_valid;
	logic [TAG_BITS-1:0] issue_tag;
	logic [TAG_BITS-1:0] src1_tag;
	logic                src1_ready;
	logic [xlen-1:0]     src1_value;
	logic [TAG_BITS-1:0] src2_tag;
	logic                src2_ready;
	logic [xlen-1:0]     src2_value;
	logic [xlen-1:0]     pc;
	logic [31:0]         inst;
	opa_sel_e            opa_select;
	opb_sel_e            opb_select;
	alu_func_e           alu_func;
	logic                cond_branch;
	logic                uncond_branch;
	logic                squash;
	logic                cdb_valid;
	logic [TAG_BITS-1:0] cdb_tag;
	logic [xlen-1:0]     cdb_value;
	logic                busy;
	logic                done;
	logic [TAG_BITS-1:0] done_tag;
	logic [xlen-1:0]     result;
	logic                take_branch;

	expect_t             expected[$];
	logic [31:0]         rng_state = 32'h66e85d8b;
	int                  cycles = 0;
	int                  issued = 0;
	int                  checks = 0;
	int                  errors = 0;
	int                  test_errors = 0;
	int                  tests = 0;
	string               test_name = "reset";
	bit                  chained = 1'b0;
	bit                  snoop_pending = 1'b0; // cdb broadcast in the issue cycle
	logic [TAG_BITS-1:0] snoop_tag;
	logic [xlen-1:0]     snoop_value;

	fu_alu #(.TAG_BITS(TAG_BITS)) u_fu_alu (.*);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// expected {take_branch, result} straight from the RV32 rules
	function automatic logic [xlen:0] reference(input instr_t in);
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] r;
		logic            taken;
		case (in.opa_sel)
			opa_is_rs1: a = in.rs1;
			opa_is_npc: a = in.pc + 4;
			opa_is_pc:  a = in.pc;
			default:    a = '0;
		endcase
		case (in.opb_sel)
			opb_is_rs2:   b = in.rs2;
			opb_is_i_imm: b = xlen'($signed(in.inst[31:20]));
			opb_is_s_imm: b = xlen'($signed({in.inst[31:25], in.inst[11:7]}));
			opb_is_b_imm: b = xlen'($signed({in.inst[31], in.inst[7], in.inst[30:25],
				in.inst[11:8], 1'b0}));
			opb_is_u_imm: b = {in.inst[31:12], 12'h000};
			opb_is_j_imm: b = xlen'($signed({in.inst[31], in.inst[19:12], in.inst[20],
				in.inst[30:21], 1'b0}));
			default:      b = '0;
		endcase
		case (in.func)
			alu_add:    r = a + b;
			alu_sub:    r = a - b;
			alu_and:    r = a & b;
			alu_or:     r = a | b;
			alu_xor:    r = a ^ b;
			alu_slt:    r = {31'b0, $signed(a) < $signed(b)};
			alu_sltu:   r = {31'b0, a < b};
			alu_sll:    r = a << b[4:0];
			alu_srl:    r = a >> b[4:0];
			alu_sra:    r = xlen'($signed(a) >>> b[4:0]);
			alu_mul:    r = xlen'(longint'(a) * longint'(b));
			alu_mulh:   r = xlen'((longint'($signed(a)) * longint'($signed(b))) >> 32);
			alu_mulhsu: r = xlen'((longint'($signed(a)) * longint'(b)) >> 32);
			alu_mulhu:  r = xlen'((longint'(a) * longint'(b)) >> 32);
			default:    r = '0;
		endcase
		case (in.inst[14:12])
			3'b000:  taken = in.rs1 == in.rs2;
			3'b001:  taken = in.rs1 != in.rs2;
			3'b100:  taken = $signed(in.rs1) < $signed(in.rs2);
			3'b101:  taken = $signed(in.rs1) >= $signed(in.rs2);
			3'b110:  taken = in.rs1 < in.rs2;
			3'b111:  taken = in.rs1 >= in.rs2;
			default: taken = 1'b0;
		endcase
		return {in.uncond || (in.cond && taken), r};
	endfunction

	function automatic instr_t random_instr(input logic [TAG_BITS-1:0] tag);
		instr_t in;
		in.tag     = tag;
		in.t1      = '0;
		in.t2      = '0;
		in.func    = alu_add;
		in.opa_sel = opa_is_rs1;
		in.opb_sel = opb_is_rs2;
		in.rs1     = next_random();
		in.rs2     = next_random();
		in.pc      = next_random() & 32'hffff_fffc;
		in.inst    = next_random();
		in.cond    = 1'b0;
		in.uncond  = 1'b0;
		return in;
	endfunction

	task automatic note_failure(input string what);
		$display("%s: %s", test_name, what);
		errors++;
		test_errors++;
	endtask

	task automatic check_result(input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: result expected %h, actual %h", test_name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_tag(input logic [TAG_BITS-1:0] exp, input logic [TAG_BITS-1:0] act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: done_tag expected %0d, actual %0d", test_name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_take(input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: take_branch expected %b, actual %b", test_name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic wait_idle();
		@(negedge clock);
		while (busy)
			@(negedge clock);
	endtask

	// ready[0] is source 1, a source that is not ready gets a wrong value
	task automatic send(input instr_t in, input logic [1:0] ready, input bit chain,
	                    input bit track);
		logic [xlen:0] ref_out;
		expect_t       e;
		if (!chained)
			wait_idle();
		@(posedge clock);
		issue_valid   <= 1'b1;
		issue_tag     <= in.tag;
		src1_tag      <= in.t1;
		src1_ready    <= ready[0];
		src1_value    <= ready[0] ? in.rs1 : ~in.rs1;
		src2_tag      <= in.t2;
		src2_ready    <= ready[1];
		src2_value    <= ready[1] ? in.rs2 : ~in.rs2;
		pc            <= in.pc;
		inst          <= in.inst;
		opa_select    <= in.opa_sel;
		opb_select    <= in.opb_sel;
		alu_func      <= in.func;
		cond_branch   <= in.cond;
		uncond_branch <= in.uncond;
		cdb_valid     <= snoop_pending;
		cdb_tag       <= snoop_tag;
		cdb_value     <= snoop_value;
		issued++;
		if (track) begin
			ref_out   = reference(in);
			e.tag     = in.tag;
			e.result  = ref_out[xlen-1:0];
			e.take    = ref_out[xlen];
			e.timed   = (ready == 2'b11) || snoop_pending;
			e.at_edge = cycles + 1;
			expected.push_back(e);
		end
		snoop_pending = 1'b0;
		chained = chain;
		if (!chain) begin
			@(posedge clock);
			issue_valid <= 1'b0;
			cdb_valid   <= 1'b0;
		end
	endtask

	task automatic broadcast(input logic [TAG_BITS-1:0] tag, input logic [xlen-1:0] value);
		@(posedge clock);
		cdb_valid <= 1'b1;
		cdb_tag   <= tag;
		cdb_value <= value;
		@(posedge clock);
		cdb_valid <= 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests++;
	endtask

	task automatic end_test();
		while (expected.size() != 0)
			@(negedge clock);
		repeat (4) @(negedge clock); // catch stray done pulses
		$display("test %-10s %0d errors", test_name, test_errors);
	endtask

	// compare each done against the oldest issued instruction
	always @(negedge clock) begin
		expect_t e;
		if (arst_n && done) begin
			if (expected.size() == 0) begin
				note_failure($sformatf("done with tag %0d but nothing is in flight", done_tag));
			end else begin
				e = expected.pop_front();
				check_result(e.result, result);
				check_tag(e.tag, done_tag);
				check_take(e.take, take_branch);
				if (e.timed && cycles != e.at_edge + 3)
					note_failure($sformatf("tag %0d done at cycle %0d, expected at cycle %0d",
						e.tag, cycles, e.at_edge + 3));
			end
		end else if (arst_n && take_branch) begin
			note_failure("take_branch high while done is low");
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > 20 * issued + 200) begin
			$display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		instr_t in;
		logic [xlen-1:0] v;
		arst_n        = 1'b0;
		issue_valid   = 1'b0;
		issue_tag     = '0;
		src1_tag      = '0;
		src1_ready    = 1'b0;
		src1_value    = '0;
		src2_tag      = '0;
		src2_ready    = 1'b0;
		src2_value    = '0;
		pc            = '0;
		inst          = '0;
		opa_select    = opa_is_rs1;
		opb_select    = opb_is_rs2;
		alu_func      = alu_add;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		squash        = 1'b0;
		cdb_valid     = 1'b0;
		cdb_tag       = '0;
		cdb_value     = '0;
		repeat (5) @(posedge clock);
		arst_n <= 1'b1;

		begin_test("alu_ops");
		for (int r = 0; r < 3; r++) begin
			for (int f = 0; f < 14; f++) begin
				in = random_instr(TAG_BITS'(f + r));
				in.func = alu_func_e'(f[3:0]);
				if (r == 2) begin
					// negative times large unsigned for the high products
					in.rs1 = 32'h8000_0003 ^ (next_random() & 32'h0000_fff0);
					in.rs2 = 32'hffff_fff0 | next_random();
				end
				send(in, 2'b11, 1'b0, 1'b1);
			end
		end
		end_test();

		begin_test("operands");
		for (int r = 0; r < 2; r++) begin
			for (int a = 0; a < 4; a++) begin
				for (int b = 0; b < 6; b++) begin
					in = random_instr(TAG_BITS'(a * 6 + b));
					in.opa_sel = opa_sel_e'(a[1:0]);
					in.opb_sel = opb_sel_e'(b[2:0]);
					send(in, 2'b11, 1'b0, 1'b1);
				end
			end
		end
		end_test();

		begin_test("branches");
		for (int r = 0; r < 4; r++) begin
			for (int k = 0; k < 8; k++) begin
				in = random_instr(TAG_BITS'(k));
				in.inst[14:12] = k[2:0];
				in.cond = 1'b1;
				if (r == 0)
					in.rs2 = in.rs1;
				else if (r == 1)
					in.rs2 = ~in.rs1; // opposite signs
				send(in, 2'b11, 1'b0, 1'b1);
			end
		end
		in = random_instr(5'd30);
		in.uncond = 1'b1;
		in.opa_sel = opa_is_npc;
		in.opb_sel = opb_is_j_imm;
		send(in, 2'b11, 1'b0, 1'b1);
		in = random_instr(5'd31); // beq funct3 with equal values, not a branch
		in.inst[14:12] = 3'b000;
		in.rs2 = in.rs1;
		send(in, 2'b11, 1'b0, 1'b1);
		end_test();

		begin_test("wakeup");
		v = next_random();
		in = random_instr(5'd1);
		in.t1 = 5'd3;
		in.rs1 = v;
		send(in, 2'b10, 1'b0, 1'b1);
		@(negedge clock);
		if (!busy)
			note_failure("busy low while source 1 is waiting");
		broadcast(5'd4, ~v);
		repeat (3) begin
			@(negedge clock);
			if (!busy)
				note_failure("a broadcast with another tag woke the waiting source");
		end
		broadcast(5'd3, v);
		in = random_instr(5'd2);
		in.func = alu_sub;
		in.t1 = 5'd5;
		in.t2 = 5'd6;
		send(in, 2'b00, 1'b0, 1'b1);
		broadcast(5'd6, in.rs2);
		broadcast(5'd5, in.rs1);
		in = random_instr(5'd7);
		in.func = alu_xor;
		in.t2 = 5'd9;
		snoop_pending = 1'b1; // value arrives in the issue cycle
		snoop_tag = 5'd9;
		snoop_value = in.rs2;
		send(in, 2'b01, 1'b0, 1'b1);
		end_test();

		begin_test("burst");
		for (int k = 0; k < 8; k++) begin
			in = random_instr(TAG_BITS'(16 + k));
			in.func = alu_func_e'(4'(next_random() % 14));
			send(in, 2'b11, k != 7, 1'b1);
		end
		end_test();

		begin_test("squash");
		send(random_instr(5'd10), 2'b11, 1'b1, 1'b0);
		send(random_instr(5'd11), 2'b11, 1'b0, 1'b0);
		squash <= 1'b1; // first in stage 1, second launching from the slot
		@(posedge clock);
		squash <= 1'b0;
		in = random_instr(5'd12);
		in.t1 = 5'd12;
		send(in, 2'b10, 1'b0, 1'b0);
		squash <= 1'b1;
		@(posedge clock);
		squash <= 1'b0;
		broadcast(5'd12, in.rs1);
		repeat (6) @(negedge clock);
		for (int k = 0; k < 3; k++)
			send(random_instr(TAG_BITS'(13 + k)), 2'b11, k != 2, 1'b1);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
